/* src/bridge_defs.svh */
`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// bus widths
`define BR_DATA_W      8
`define BR_EP_W        4
`define BR_LEN_W       12
`define BR_GPIO_W      10

// endpoint map
`define BR_EP_CONFIG   0          // CDC line coding
`define BR_EP_GPIO     8          // parallel output

// packet lengths in bytes
`define BR_LC_BYTES    7
`define BR_GPIO_BYTES  2

// line coding after reset, stop bits and parity are 0
`define BR_LC_BAUD_RST 115200
`define BR_LC_DATA_RST 8

// heartbeat
`define BR_LED_HALF    30000000   // half period, 0.5 s at 60 MHz

`endif

/* src/usb_ep_pkg.sv */
`include "bridge_defs.svh"

package usb_ep_pkg;

  // ========================================
  // endpoint side of the device controller
  // ========================================

  // endpoint number as presented by the controller
  typedef logic [`BR_EP_W-1:0] ep_num_t;

  // position of a byte within one packet
  // counters of this type saturate at 15, so a long packet never
  // wraps back onto a valid short length
  typedef logic [3:0] byte_idx_t;

endpackage

/* src/line_coding_pkg.sv */
`include "bridge_defs.svh"

package line_coding_pkg;

  // ========================================
  // CDC line coding record
  // ========================================

  // fields listed from the top bit down, so wire byte 0 sits in bits 7:0
  typedef struct packed {
    logic [`BR_DATA_W-1:0]   data_bits;   // wire byte 6
    logic [`BR_DATA_W-1:0]   parity;      // wire byte 5
    logic [`BR_DATA_W-1:0]   stop_bits;   // wire byte 4
    logic [4*`BR_DATA_W-1:0] baud;        // wire bytes 3..0, little-endian
  } lc_fields_t;

  // same record as bytes, index = wire position
  typedef logic [`BR_LC_BYTES-1:0][`BR_DATA_W-1:0] lc_bytes_t;

  // endpoint 0 writes and reads bytes, the uart ports see fields
  typedef union packed {
    lc_fields_t fields;
    lc_bytes_t  bytes;
  } line_coding_u;

endpackage

/* src/rx_byte_if.sv */
`timescale 1ns/1ps
`include "bridge_defs.svh"

// received bytes and packet end events, capture -> endpoint sinks
interface rx_byte_if import usb_ep_pkg::*; ();

  ep_num_t               ep;       // endpoint of the packet
  logic [`BR_DATA_W-1:0] data;     // byte payload
  byte_idx_t             idx;      // position in packet
  logic                  valid;    // one strobe per byte
  logic                  commit;   // packet ended good
  logic                  abort;    // packet ended bad

  modport capture (
    output ep, data, idx, valid, commit, abort
  );

  modport sink (
    input  ep, data, idx, valid, commit, abort
  );

endinterface

/* src/usb_rx_capture.sv */
`timescale 1ns/1ps
`include "bridge_defs.svh"

module usb_rx_capture import usb_ep_pkg::*; (
  input  logic                  PHY_CLKOUT,
  input  logic                  RESET_IN,
  input  ep_num_t               endpt_i,
  input  logic [`BR_DATA_W-1:0] rxdat_i,
  input  logic                  rxval_i,
  input  logic                  rxact_i,
  input  logic                  rxpktval_i,
  input  logic                  setup_i,
  rx_byte_if.capture            rx
);

  // ========================================
  // input register stage
  // ========================================
  ep_num_t               ep_q;
  logic [`BR_DATA_W-1:0] dat_q;
  logic                  val_q;
  logic                  act_q;
  logic                  act_d;        // act_q delayed, for edges
  logic                  pktval_q;
  logic                  setup_q;

  always_ff @(posedge PHY_CLKOUT) begin
    if (RESET_IN) begin
      val_q    <= 1'b0;
      act_q    <= 1'b0;
      act_d    <= 1'b0;
      pktval_q <= 1'b0;
      setup_q  <= 1'b0;
    end else begin
      val_q    <= rxval_i;
      act_q    <= rxact_i;
      act_d    <= act_q;
      pktval_q <= rxpktval_i;
      setup_q  <= setup_i;
    end
  end

  always_ff @(posedge PHY_CLKOUT) begin
    ep_q  <= endpt_i;
    dat_q <= rxdat_i;
  end

  // ========================================
  // byte position and packet end
  // ========================================
  logic      pkt_start;
  logic      pkt_end;
  logic      pkt_good;
  logic      byte_take;
  logic      pkt_seen;                 // rxpktval seen in this packet
  byte_idx_t byte_cnt;
  byte_idx_t idx_base;

  assign pkt_start = act_q & ~act_d;
  assign pkt_end   = ~act_q & act_d;
  assign pkt_good  = pktval_q & act_q;
  assign byte_take = val_q & act_q & ~setup_q;   // setup bytes dropped
  assign idx_base  = pkt_start ? '0 : byte_cnt;

  always_ff @(posedge PHY_CLKOUT) begin
    if (RESET_IN) begin
      byte_cnt  <= '0;
      pkt_seen  <= 1'b0;
      rx.valid  <= 1'b0;
      rx.commit <= 1'b0;
      rx.abort  <= 1'b0;
    end else begin
      rx.valid  <= byte_take;
      rx.commit <= pkt_good & ~setup_q;
      // a setup packet never reaches the sinks as good
      rx.abort  <= (pkt_good & setup_q) | (pkt_end & ~pkt_seen);
      if (pkt_good) begin
        pkt_seen <= 1'b1;
      end else if (pkt_start) begin
        pkt_seen <= 1'b0;
      end
      if (byte_take) begin
        byte_cnt <= (idx_base == '1) ? idx_base : idx_base + 1'b1;  // saturate
      end else if (pkt_start) begin
        byte_cnt <= '0;
      end
    end
  end

  always_ff @(posedge PHY_CLKOUT) begin
    rx.ep   <= ep_q;
    rx.data <= dat_q;
    rx.idx  <= idx_base;
  end

endmodule

/* src/line_coding_regs.sv */
`timescale 1ns/1ps
`include "bridge_defs.svh"

module line_coding_regs import usb_ep_pkg::*, line_coding_pkg::*; (
  input  logic         PHY_CLKOUT,
  input  logic         RESET_IN,
  rx_byte_if.sink      rx,
  output line_coding_u lc_o
);

  localparam lc_fields_t LC_RST = '{
    data_bits: `BR_LC_DATA_RST,
    parity:    '0,
    stop_bits: '0,
    baud:      `BR_LC_BAUD_RST
  };

  line_coding_u stage;                 // packet in flight
  byte_idx_t    stage_cnt;             // bytes staged so far
  logic         ep_hit;

  assign ep_hit = (rx.ep == ep_num_t'(`BR_EP_CONFIG));

  // ========================================
  // staging by byte index
  // ========================================
  always_ff @(posedge PHY_CLKOUT) begin
    if (rx.valid && ep_hit && (rx.idx < `BR_LC_BYTES)) begin
      stage.bytes[rx.idx] <= rx.data;
    end
  end

  // ========================================
  // count and commit
  // ========================================
  always_ff @(posedge PHY_CLKOUT) begin
    if (RESET_IN) begin
      stage_cnt   <= '0;
      lc_o.fields <= LC_RST;
    end else if (rx.commit || rx.abort) begin
      // only a complete record replaces the live one
      if (rx.commit && ep_hit && (stage_cnt == `BR_LC_BYTES)) begin
        lc_o <= stage;
      end
      stage_cnt <= '0;                 // staging discarded either way
    end else if (rx.valid && ep_hit && (stage_cnt != '1)) begin
      stage_cnt <= stage_cnt + 1'b1;
    end
  end

endmodule

/* src/gpio_endpoint.sv */
`timescale 1ns/1ps
`include "bridge_defs.svh"

module gpio_endpoint import usb_ep_pkg::*; (
  input  logic                  PHY_CLKOUT,
  input  logic                  RESET_IN,
  rx_byte_if.sink               rx,
  output logic [`BR_GPIO_W-1:0] gpio_o
);

  logic [`BR_DATA_W-1:0] byte0;        // output bits 7..0
  logic [`BR_DATA_W-1:0] byte1;        // low bits give 9..8
  byte_idx_t             cnt;
  logic                  ep_hit;

  assign ep_hit = (rx.ep == ep_num_t'(`BR_EP_GPIO));

  always_ff @(posedge PHY_CLKOUT) begin
    if (rx.valid && ep_hit) begin
      if (rx.idx == byte_idx_t'(0)) begin
        byte0 <= rx.data;
      end
      if (rx.idx == byte_idx_t'(1)) begin
        byte1 <= rx.data;
      end
    end
  end

  always_ff @(posedge PHY_CLKOUT) begin
    if (RESET_IN) begin
      cnt    <= '0;
      gpio_o <= '0;
    end else if (rx.commit || rx.abort) begin
      if (rx.commit && ep_hit && (cnt >= `BR_GPIO_BYTES)) begin
        gpio_o <= {byte1[`BR_GPIO_W-`BR_DATA_W-1:0], byte0};  // extra bytes ignored
      end
      cnt <= '0;
    end else if (rx.valid && ep_hit && (cnt != '1)) begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

/* src/ep_tx_mux.sv */
`timescale 1ns/1ps
`include "bridge_defs.svh"

module ep_tx_mux import usb_ep_pkg::*, line_coding_pkg::*; (
  input  logic                  PHY_CLKOUT,
  input  logic                  RESET_IN,
  input  ep_num_t               endpt_i,
  input  logic                  setup_i,
  input  logic                  txact_i,
  input  logic                  txpop_i,
  input  line_coding_u          lc_i,
  output logic                  rxrdy_o,
  output logic [`BR_DATA_W-1:0] txdat_o,
  output logic [`BR_LEN_W-1:0]  txdat_len_o,
  output logic                  txcork_o,
  output logic                  txval_o
);

  localparam logic [`BR_LEN_W-1:0] LC_LEN  = `BR_LC_BYTES;
  localparam byte_idx_t            RD_LAST = `BR_LC_BYTES - 1;

  logic      ep_cfg;
  logic      ep_gpio;
  logic      cfg_send;                 // endpoint 0 answering a read
  logic      txact_q;
  byte_idx_t rd_idx;

  // ========================================
  // endpoint decode
  // ========================================
  always_comb begin
    ep_cfg  = 1'b0;
    ep_gpio = 1'b0;
    case (endpt_i)
      ep_num_t'(`BR_EP_CONFIG): ep_cfg  = 1'b1;
      ep_num_t'(`BR_EP_GPIO):   ep_gpio = 1'b1;
      default: ;                       // unused endpoints stay corked
    endcase
  end

  assign cfg_send    = ep_cfg & ~setup_i;
  assign rxrdy_o     = ep_cfg | ep_gpio;
  assign txval_o     = cfg_send;
  assign txcork_o    = ~cfg_send;
  assign txdat_len_o = cfg_send ? LC_LEN : '0;
  assign txdat_o     = cfg_send ? lc_i.bytes[rd_idx] : '0;

  // ========================================
  // read pointer into the record
  // ========================================
  always_ff @(posedge PHY_CLKOUT) begin
    if (RESET_IN) begin
      txact_q <= 1'b0;
      rd_idx  <= '0;
    end else begin
      txact_q <= txact_i;
      if (txact_i && !txact_q) begin
        rd_idx <= '0;                  // new IN transfer
      end else if (txpop_i && cfg_send && (rd_idx != RD_LAST)) begin
        rd_idx <= rd_idx + 1'b1;
      end
    end
  end

endmodule

/* src/heartbeat_led.sv */
`timescale 1ns/1ps
`include "bridge_defs.svh"

module heartbeat_led #(
  parameter int unsigned LED_HALF = `BR_LED_HALF
) (
  input  logic PHY_CLKOUT,
  input  logic RESET_IN,
  output logic led_o
);

  localparam int unsigned      CNT_W    = (LED_HALF > 1) ? $clog2(LED_HALF) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(LED_HALF - 1);

  logic [CNT_W-1:0] cnt;               // cycles into the half period

  always_ff @(posedge PHY_CLKOUT) begin
    if (RESET_IN) begin
      cnt   <= '0;
      led_o <= 1'b0;
    end else if (cnt == CNT_LAST) begin
      cnt   <= '0;
      led_o <= ~led_o;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

/* src/usb_bridge_top.sv */
`timescale 1ns/1ps
`include "bridge_defs.svh"

module usb_bridge_top import usb_ep_pkg::*, line_coding_pkg::*; #(
  parameter int unsigned LED_HALF = `BR_LED_HALF
) (
  input  logic                    PHY_CLKOUT,
  input  logic                    RESET_IN,
  // device controller, endpoint side
  input  ep_num_t                 endpt_i,
  input  logic [`BR_DATA_W-1:0]   rxdat_i,
  input  logic                    rxval_i,
  input  logic                    rxact_i,
  input  logic                    rxpktval_i,
  input  logic                    setup_i,
  input  logic                    txact_i,
  input  logic                    txpop_i,
  output logic                    rxrdy_o,
  output logic [`BR_DATA_W-1:0]   txdat_o,
  output logic [`BR_LEN_W-1:0]    txdat_len_o,
  output logic                    txcork_o,
  output logic                    txval_o,
  // endpoint 8
  output logic [`BR_GPIO_W-1:0]   parallel_gpio_o,
  // line coding
  output logic [4*`BR_DATA_W-1:0] uart_baud_o,
  output logic [`BR_DATA_W-1:0]   uart_stop_bits_o,
  output logic [`BR_DATA_W-1:0]   uart_parity_o,
  output logic [`BR_DATA_W-1:0]   uart_data_bits_o,
  output logic                    led_o
);

  rx_byte_if    rx_bus ();
  line_coding_u lc;                    // live record from endpoint 0

  // ========================================
  // receive path
  // ========================================
  usb_rx_capture u_rx_capture (
    .PHY_CLKOUT (PHY_CLKOUT),
    .RESET_IN   (RESET_IN),
    .endpt_i    (endpt_i),
    .rxdat_i    (rxdat_i),
    .rxval_i    (rxval_i),
    .rxact_i    (rxact_i),
    .rxpktval_i (rxpktval_i),
    .setup_i    (setup_i),
    .rx         (rx_bus)
  );

  line_coding_regs u_line_coding (
    .PHY_CLKOUT (PHY_CLKOUT),
    .RESET_IN   (RESET_IN),
    .rx         (rx_bus),
    .lc_o       (lc)
  );

  gpio_endpoint u_gpio (
    .PHY_CLKOUT (PHY_CLKOUT),
    .RESET_IN   (RESET_IN),
    .rx         (rx_bus),
    .gpio_o     (parallel_gpio_o)
  );

  // ========================================
  // routing and transmit path
  // ========================================
  ep_tx_mux u_tx_mux (
    .PHY_CLKOUT  (PHY_CLKOUT),
    .RESET_IN    (RESET_IN),
    .endpt_i     (endpt_i),
    .setup_i     (setup_i),
    .txact_i     (txact_i),
    .txpop_i     (txpop_i),
    .lc_i        (lc),
    .rxrdy_o     (rxrdy_o),
    .txdat_o     (txdat_o),
    .txdat_len_o (txdat_len_o),
    .txcork_o    (txcork_o),
    .txval_o     (txval_o)
  );

  heartbeat_led #(
    .LED_HALF (LED_HALF)
  ) u_led (
    .PHY_CLKOUT (PHY_CLKOUT),
    .RESET_IN   (RESET_IN),
    .led_o      (led_o)
  );

  assign uart_baud_o      = lc.fields.baud;
  assign uart_stop_bits_o = lc.fields.stop_bits;
  assign uart_parity_o    = lc.fields.parity;
  assign uart_data_bits_o = lc.fields.data_bits;

endmodule

/* sim/tb_usb_bridge.sv */
`timescale 1ns/1ps

module tb_usb_bridge;

  localparam int LED_HALF = 50;
  localparam int LC_LEN   = 7;          // line coding record length

  logic        PHY_CLKOUT, RESET_IN;
  logic [3:0]  endpt_i;
  logic [7:0]  rxdat_i, txdat_o, uart_stop_bits_o, uart_parity_o, uart_data_bits_o;
  logic        rxval_i, rxact_i, rxpktval_i, setup_i, txact_i, txpop_i;
  logic        rxrdy_o, txcork_o, txval_o, led_o;
  logic [11:0] txdat_len_o;
  logic [9:0]  parallel_gpio_o;
  logic [31:0] uart_baud_o;

  string      stim_lines[$];
  bit         stim_ready;
  int         cyc, checks, errors;      // cyc counts edges since reset release
  string      test_name, op;            // fields of the current stim line
  int         ep, n;
  logic [7:0] d[8];
  int         exp_baud, exp_stop, exp_par, exp_data, exp_gpio;

  usb_bridge_top #(.LED_HALF(LED_HALF)) UUT (.*);

  initial begin
    PHY_CLKOUT = 1'b0;
    forever #20 PHY_CLKOUT = ~PHY_CLKOUT;
  end

  always @(posedge PHY_CLKOUT) begin
    cyc <= RESET_IN ? 0 : cyc + 1;
  end

  // ========================================
  // helpers
  // ========================================
  task automatic next_cycle();
    @(posedge PHY_CLKOUT);
    #2;                                 // drive and sample point
  endtask

  task automatic compare_val(input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    checks++;
    assert (act_v === exp_v) else begin
      errors++;
      $display("[FAIL] %s: %s expected 0x%0h actual 0x%0h", test_name, what, exp_v, act_v);
    end
  endtask

  task automatic verify_outputs();
    compare_val("uart_baud_o", exp_baud, uart_baud_o);
    compare_val("uart_stop_bits_o", exp_stop, 32'(uart_stop_bits_o));
    compare_val("uart_parity_o", exp_par, 32'(uart_parity_o));
    compare_val("uart_data_bits_o", exp_data, 32'(uart_data_bits_o));
    compare_val("parallel_gpio_o", exp_gpio, 32'(parallel_gpio_o));
  endtask

  task automatic send_packet(input bit setup, input bit good);
    int i;
    int gap;
    endpt_i = 4'(ep);
    setup_i = setup;
    rxact_i = 1'b1;
    for (i = 0; i < n; i++) begin
      gap = int'($urandom % 4);         // idle cycles before the byte
      repeat (gap) next_cycle();
      rxdat_i = d[i];
      rxval_i = 1'b1;
      next_cycle();
      rxval_i = 1'b0;
    end
    rxpktval_i = good;                  // stays low for an aborted packet
    next_cycle();
    rxpktval_i = 1'b0;
    rxact_i    = 1'b0;
    next_cycle();
    setup_i = 1'b0;
    repeat (3) next_cycle();
    verify_outputs();
  endtask

  task automatic read_record();
    int i;
    endpt_i = 4'(ep);
    txact_i = 1'b1;
    next_cycle();                       // read index clears on this edge
    compare_val("txdat_len_o", n, 32'(txdat_len_o));
    compare_val("txval_o", 1, 32'(txval_o));
    for (i = 0; i <= n; i++) begin
      // the extra pop past the end must hold the last byte
      compare_val($sformatf("txdat_o byte %0d", i), 32'(d[(i < n) ? i : n - 1]),
                  32'(txdat_o));
      txpop_i = 1'b1;
      next_cycle();
      txpop_i = 1'b0;
    end
    txact_i = 1'b0;
    next_cycle();
    verify_outputs();
  endtask

  task automatic scan_routing();
    int    e;
    string tag;
    for (e = 0; e < 16; e++) begin
      endpt_i = 4'(e);
      tag     = $sformatf(" ep %0d", e);
      #10;                              // outputs are combinational
      compare_val({"rxrdy_o", tag}, 32'(e == 0 || e == 8), 32'(rxrdy_o));
      compare_val({"txval_o", tag}, 32'(e == 0), 32'(txval_o));
      compare_val({"txcork_o", tag}, 32'(e != 0), 32'(txcork_o));
      compare_val({"txdat_len_o", tag}, (e == 0) ? LC_LEN : 0, 32'(txdat_len_o));
      if (e != 0) begin
        compare_val({"txdat_o", tag}, 0, 32'(txdat_o));
      end
      next_cycle();
    end
    // a setup transaction on endpoint 0 sends nothing
    endpt_i = '0;
    setup_i = 1'b1;
    #10;
    compare_val("rxrdy_o in setup", 1, 32'(rxrdy_o));
    compare_val("txval_o in setup", 0, 32'(txval_o));
    compare_val("txcork_o in setup", 1, 32'(txcork_o));
    compare_val("txdat_len_o in setup", 0, 32'(txdat_len_o));
    compare_val("txdat_o in setup", 0, 32'(txdat_o));
    next_cycle();
    setup_i = 1'b0;
  endtask

  task automatic watch_led(input int half);
    if (cyc >= half - 1) begin
      errors++;
      $display("led test %s started after the first toggle was due", test_name);
      return;
    end
    while (cyc < half - 1) begin
      next_cycle();
    end
    compare_val("led_o before first toggle", 0, 32'(led_o));
    next_cycle();
    compare_val("led_o after first toggle", 1, 32'(led_o));
    while (cyc < 2 * half - 1) begin
      next_cycle();
    end
    compare_val("led_o before second toggle", 1, 32'(led_o));
    next_cycle();
    compare_val("led_o after second toggle", 0, 32'(led_o));
  endtask

  task automatic run_line(input string line);
    int got;
    got = $sscanf(line, "%s %s %d %d %h %h %h %h %h %h %h %h %d %d %d %d %d",
                  test_name, op, ep, n, d[0], d[1], d[2], d[3], d[4], d[5], d[6], d[7],
                  exp_baud, exp_stop, exp_par, exp_data, exp_gpio);
    if (got != 17) begin
      errors++;
      $display("stimulus line could not be parsed: %s", line);
      return;
    end
    case (op)
      "rst": begin
        endpt_i = 4'(ep);
        #10;
        compare_val("led_o", 0, 32'(led_o));
        compare_val("txval_o", 0, 32'(txval_o));
        verify_outputs();
        next_cycle();
      end
      "led":   watch_led(n);
      "wr":    send_packet(1'b0, 1'b1);
      "ab":    send_packet(1'b0, 1'b0);
      "su":    send_packet(1'b1, 1'b1);
      "rd":    read_record();
      "rt":    scan_routing();
      default: begin
        errors++;
        $display("test %s has an unknown operation %s", test_name, op);
      end
    endcase
  endtask

  // ========================================
  // main sequence and watchdog
  // ========================================
  initial begin
    int    fd;
    string line;
    RESET_IN   = 1'b1;
    endpt_i    = '0;
    rxdat_i    = '0;
    rxval_i    = 1'b0;
    rxact_i    = 1'b0;
    rxpktval_i = 1'b0;
    setup_i    = 1'b0;
    txact_i    = 1'b0;
    txpop_i    = 1'b0;
    checks     = 0;
    errors     = 0;
    void'($urandom(32'h137b_1a58));
    fd = $fopen("sim/bridge_stim.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("the stimulus file sim/bridge_stim.txt could not be opened");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line.getc(0) != "#") begin
          stim_lines.push_back(line);
        end
      end
      $fclose(fd);
      stim_ready = 1'b1;
    end
    repeat (10) @(posedge PHY_CLKOUT);
    #2;
    RESET_IN = 1'b0;
    foreach (stim_lines[idx]) begin
      run_line(stim_lines[idx]);
    end
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    longint limit_ns;
    wait (stim_ready);
    limit_ns = longint'(40) * 200 * (stim_lines.size() + 10);
    #(limit_ns);
    $display("timeout, the run did not finish within %0d ns", limit_ns);
    $display("tests failed");
    $finish;
  end

endmodule

/* sim/bridge_stim.txt */
# name op ep n d0 d1 d2 d3 d4 d5 d6 d7 baud stop parity data gpio
# bytes d0..d7 in hex, the rest decimal; for led n is the half period
reset_state  rst 3 0  00 00 00 00 00 00 00 00 115200 0 0 8 0
led_blink    led 0 50 00 00 00 00 00 00 00 00 115200 0 0 8 0
reset_read   rd  0 7  00 c2 01 00 00 00 08 00 115200 0 0 8 0
lc_write     wr  0 7  80 25 00 00 01 02 07 00 9600 1 2 7 0
lc_read      rd  0 7  80 25 00 00 01 02 07 00 9600 1 2 7 0
gpio_write   wr  8 2  a5 02 00 00 00 00 00 00 9600 1 2 7 677
gpio_extra   wr  8 4  3c fd 11 22 00 00 00 00 9600 1 2 7 316
lc_short     wr  0 6  00 c2 01 00 00 00 00 00 9600 1 2 7 316
gpio_short   wr  8 1  ff 00 00 00 00 00 00 00 9600 1 2 7 316
lc_abort     ab  0 7  00 c2 01 00 00 00 08 00 9600 1 2 7 316
gpio_abort   ab  8 2  ff 03 00 00 00 00 00 00 9600 1 2 7 316
lc_setup     su  0 7  00 c2 01 00 00 00 08 00 9600 1 2 7 316
gpio_setup   su  8 2  ff 03 00 00 00 00 00 00 9600 1 2 7 316
other_ep     wr  5 7  00 c2 01 00 00 00 08 00 9600 1 2 7 316
lc_write2    wr  0 7  00 e1 00 00 02 01 05 00 57600 2 1 5 316
lc_read2     rd  0 7  00 e1 00 00 02 01 05 00 57600 2 1 5 316
routing      rt  0 0  00 00 00 00 00 00 00 00 57600 2 1 5 316

/* project.f */
+incdir+src
src/usb_ep_pkg.sv
src/line_coding_pkg.sv
src/rx_byte_if.sv
src/usb_rx_capture.sv
src/line_coding_regs.sv
src/gpio_endpoint.sv
src/ep_tx_mux.sv
src/heartbeat_led.sv
src/usb_bridge_top.sv
sim/tb_usb_bridge.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_usb_bridge
FILELIST = project.f
OBJ_DIR  = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx "all tests passed"

clean:
	rm -rf $(OBJ_DIR)
